//--- dcache.sv
`timescale 1ns/10ps

module dcache import mem_pkg::*; #(
   parameter int INDEX_W = mem_pkg::INDEX_W
) (
   input  logic     clk,
   input  logic     i_arst_n,
   input  addr_t    i_addr,
   input  word_t    i_wdata,    // store data from core
   input  logic     i_rd_en,
   input  logic     i_wr_en,
   output word_t    o_rdata,
   output logic     o_busy,
   mem_bus_if.cache bus
);

   localparam int TAG_W = $bits(addr_t) - INDEX_W;
   localparam int LINES = 1 << INDEX_W;

   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] idx_t;

   word_t            data_mem [LINES];
   tag_t             tag_mem  [LINES];
   logic [LINES-1:0] valid_q;

   cache_state_t state_q;
   cache_state_t state_d;

   idx_t idx;
   tag_t tag;
   logic hit;
   logic fill;        // read miss returns
   logic wr_done;     // write-through access completes
   logic wr_done_q;   // cycle after a write, core still shows i_wr_en
   logic wr_start;
   logic upd;         // write hit, refresh cached word

   assign idx = i_addr[INDEX_W-1:0];
   assign tag = i_addr[$bits(addr_t)-1:INDEX_W];

   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
   assign fill     = (state_q == WAIT) && bus.vld;
   assign wr_done  = (state_q == WRITE) && bus.vld;
   assign wr_start = i_wr_en && !wr_done_q;
   assign upd      = wr_done && hit;   // miss leaves the line alone

   assign o_rdata = data_mem[idx];

   assign o_busy = (state_q != IDLE) || wr_start || (i_rd_en && !hit);

   // core holds addr and data steady while busy
   assign bus.req   = (state_q == REQ) || (state_q == WAIT) || (state_q == WRITE);
   assign bus.wr    = (state_q == WRITE);
   assign bus.addr  = i_addr;
   assign bus.wdata = i_wdata;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (wr_start) begin
               state_d = WRITE;   // every store goes to memory
            end else if (i_rd_en && !hit) begin
               state_d = REQ;
            end
         end
         REQ: begin
            state_d = WAIT;
         end
         WAIT: begin
            if (bus.vld) begin
               state_d = IDLE;
            end
         end
         WRITE: begin
            if (bus.vld) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q   <= IDLE;
         valid_q   <= '0;
         wr_done_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         wr_done_q <= wr_done;
         if (fill) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill) begin
         data_mem[idx] <= bus.rdata;
         tag_mem[idx]  <= tag;
      end else if (upd) begin
         data_mem[idx] <= i_wdata;   // same cycle memory takes the write
      end
   end

endmodule

//--- icache.sv
`timescale 1ns/10ps

module icache import mem_pkg::*; #(
   parameter int INDEX_W = mem_pkg::INDEX_W
) (
   input  logic     clk,
   input  logic     i_arst_n,
   input  addr_t    i_addr,     // pc
   input  logic     i_rd_en,
   output word_t    o_instr,
   output logic     o_busy,
   mem_bus_if.cache bus
);

   localparam int TAG_W = $bits(addr_t) - INDEX_W;
   localparam int LINES = 1 << INDEX_W;

   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] idx_t;

   word_t            data_mem [LINES];
   tag_t             tag_mem  [LINES];
   logic [LINES-1:0] valid_q;

   cache_state_t state_q;
   cache_state_t state_d;

   idx_t idx;
   tag_t tag;
   logic hit;
   logic fill;

   assign idx = i_addr[INDEX_W-1:0];
   assign tag = i_addr[$bits(addr_t)-1:INDEX_W];

   // unwritten tags read as X, the valid bit masks them
   assign hit  = valid_q[idx] && (tag_mem[idx] == tag);
   assign fill = (state_q == WAIT) && bus.vld;

   assign o_instr = data_mem[idx];   // filled word shows once back in IDLE

   // busy from the miss cycle until the cycle after vld
   assign o_busy = (state_q != IDLE) || (i_rd_en && !hit);

   // read-only side of the bus
   assign bus.req   = (state_q == REQ) || (state_q == WAIT);
   assign bus.wr    = 1'b0;
   assign bus.addr  = i_addr;   // core holds pc while busy
   assign bus.wdata = '0;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (i_rd_en && !hit) begin
               state_d = REQ;
            end
         end
         REQ: begin
            state_d = WAIT;   // arbiter grant is at least one edge away
         end
         WAIT: begin
            if (bus.vld) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= IDLE;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if (fill) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   // line storage
   always_ff @(posedge clk) begin
      if (fill) begin
         data_mem[idx] <= bus.rdata;
         tag_mem[idx]  <= tag;
      end
   end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter import mem_pkg::*; (
   input  logic       clk,
   input  logic       i_arst_n,
   mem_bus_if.arbiter ibus,
   mem_bus_if.arbiter dbus,
   output logic       o_mem_en,
   output logic       o_mem_wr,
   output addr_t      o_mem_addr,
   output word_t      o_mem_wdata,
   input  word_t      i_mem_rdata,
   input  logic       i_mem_vld
);

   logic own_q;     // an access is owned
   logic sel_d_q;   // owner is dcache

   // grant held until vld, icache wins a tie
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         own_q   <= 1'b0;
         sel_d_q <= 1'b0;
      end else if (own_q) begin
         if (i_mem_vld) begin
            own_q <= 1'b0;
         end
      end else if (ibus.req) begin
         own_q   <= 1'b1;
         sel_d_q <= 1'b0;
      end else if (dbus.req) begin
         own_q   <= 1'b1;
         sel_d_q <= 1'b1;
      end
   end

   assign o_mem_en    = own_q && (sel_d_q ? dbus.req : ibus.req);
   assign o_mem_wr    = own_q && (sel_d_q ? dbus.wr : ibus.wr);
   assign o_mem_addr  = sel_d_q ? dbus.addr : ibus.addr;
   assign o_mem_wdata = sel_d_q ? dbus.wdata : ibus.wdata;

   // read data goes to both, vld only to the owner
   assign ibus.rdata = i_mem_rdata;
   assign dbus.rdata = i_mem_rdata;
   assign ibus.vld   = own_q && !sel_d_q && i_mem_vld;
   assign dbus.vld   = own_q && sel_d_q && i_mem_vld;

endmodule

//--- mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if import mem_pkg::*; ();

   logic  req;     // held until vld
   logic  wr;      // 1 = write access
   addr_t addr;
   word_t wdata;
   word_t rdata;   // valid with vld on reads
   logic  vld;     // one cycle, end of access

   modport cache (
      output req,
      output wr,
      output addr,
      output wdata,
      input  rdata,
      input  vld
   );

   modport arbiter (
      input  req,
      input  wr,
      input  addr,
      input  wdata,
      output rdata,
      output vld
   );

endinterface

//--- mem_pkg.sv
package mem_pkg;

   // data and address are both one 16-bit word
   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;

   // default cache index width, 8 lines
   localparam int INDEX_W = 3;

   // implemented memory address bits, 256 words
   localparam int MEM_AW = 8;

   // shared by icache and dcache
   // icache never enters WRITE
   typedef enum logic [1:0] {
      IDLE,    // lookup, hit served combinationally
      REQ,     // first cycle of a fill request
      WAIT,    // holding req until memory vld
      WRITE    // write-through access in flight
   } cache_state_t;

endpackage

//--- memory_top.sv
`timescale 1ns/10ps

module memory_top import mem_pkg::*; #(
   parameter int INDEX_W = mem_pkg::INDEX_W,
   parameter int MEM_AW  = mem_pkg::MEM_AW,
   parameter int MEM_LAT = 4
) (
   input  logic  clk,
   input  logic  i_arst_n,
   // instruction side
   input  addr_t i_i_addr,
   input  logic  i_i_rd_en,
   output word_t o_instr,
   output logic  o_i_busy,
   // data side
   input  addr_t i_d_addr,
   input  word_t i_d_wdata,
   input  logic  i_d_rd_en,
   input  logic  i_d_wr_en,
   output word_t o_d_rdata,
   output logic  o_d_busy
);

   logic  mem_en;
   logic  mem_wr;
   logic  mem_vld;
   addr_t mem_addr;
   word_t mem_wdata;
   word_t mem_rdata;

   mem_bus_if ibus ();
   mem_bus_if dbus ();

   icache #(
      .INDEX_W (INDEX_W)
   ) icache_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_addr   (i_i_addr),
      .i_rd_en  (i_i_rd_en),
      .o_instr  (o_instr),
      .o_busy   (o_i_busy),
      .bus      (ibus.cache)
   );

   dcache #(
      .INDEX_W (INDEX_W)
   ) dcache_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_addr   (i_d_addr),
      .i_wdata  (i_d_wdata),
      .i_rd_en  (i_d_rd_en),
      .i_wr_en  (i_d_wr_en),
      .o_rdata  (o_d_rdata),
      .o_busy   (o_d_busy),
      .bus      (dbus.cache)
   );

   // icache has priority on the shared port
   mem_arbiter arb_i (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .ibus        (ibus.arbiter),
      .dbus        (dbus.arbiter),
      .o_mem_en    (mem_en),
      .o_mem_wr    (mem_wr),
      .o_mem_addr  (mem_addr),
      .o_mem_wdata (mem_wdata),
      .i_mem_rdata (mem_rdata),
      .i_mem_vld   (mem_vld)
   );

   multicycle_mem #(
      .MEM_AW  (MEM_AW),
      .MEM_LAT (MEM_LAT)
   ) mem_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_en     (mem_en),
      .i_wr     (mem_wr),
      .i_addr   (mem_addr),
      .i_wdata  (mem_wdata),
      .o_rdata  (mem_rdata),
      .o_vld    (mem_vld)
   );

endmodule

//--- multicycle_mem.sv
`timescale 1ns/10ps

module multicycle_mem import mem_pkg::*; #(
   parameter int MEM_AW  = mem_pkg::MEM_AW,
   parameter int MEM_LAT = 4   // cycles from accept to vld, at least 1
) (
   input  logic  clk,
   input  logic  i_arst_n,
   input  logic  i_en,
   input  logic  i_wr,
   input  addr_t i_addr,
   input  word_t i_wdata,
   output word_t o_rdata,
   output logic  o_vld
);

   localparam int DEPTH = 1 << MEM_AW;
   localparam int CNT_W = $clog2(MEM_LAT + 1);

   word_t mem [DEPTH];

   logic             busy_q;
   logic [CNT_W-1:0] cnt_q;
   logic [MEM_AW-1:0] addr_q;
   logic             wr_q;
   word_t            wdata_q;

   logic accept;
   logic done;

   // en is ignored during the vld cycle, requester still holds it
   assign accept = i_en && !busy_q && !o_vld;
   assign done   = busy_q && (cnt_q == CNT_W'(MEM_LAT - 1));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         o_vld  <= 1'b0;
      end else begin
         o_vld <= done;   // single-cycle pulse
         if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else if (done) begin
            busy_q <= 1'b0;
         end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // request latch and array
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= i_addr[MEM_AW-1:0];   // upper bits not implemented
         wr_q    <= i_wr;
         wdata_q <= i_wdata;
      end
      if (done) begin
         if (wr_q) begin
            mem[addr_q] <= wdata_q;
         end else begin
            o_rdata <= mem[addr_q];
         end
      end
   end

endmodule

//--- sim.f
mem_pkg.sv
mem_bus_if.sv
icache.sv
dcache.sv
mem_arbiter.sv
multicycle_mem.sv
memory_top.sv
tb_memory.sv

//--- tb_memory.sv
`timescale 1ns/10ps

module tb_memory import mem_pkg::*; ();

   localparam int T_INDEX_W = 3;
   localparam int T_MEM_AW  = 8;
   localparam int T_MEM_LAT = 4;

   // 32 in test 1, 1, 16, 6, 2, then 4 in test 6
   localparam int N_ACCESS   = 61;
   localparam int WDOG_CYC   = N_ACCESS * (T_MEM_LAT + 4) * 2 + 200;

   logic  clk;
   logic  i_arst_n;
   addr_t i_i_addr;
   logic  i_i_rd_en;
   word_t o_instr;
   logic  o_i_busy;
   addr_t i_d_addr;
   word_t i_d_wdata;
   logic  i_d_rd_en;
   logic  i_d_wr_en;
   word_t o_d_rdata;
   logic  o_d_busy;

   word_t shadow [1 << T_MEM_AW];   // reference memory
   addr_t test_addr [16];

   int checks = 0;
   int errors = 0;

   memory_top #(
      .INDEX_W (T_INDEX_W),
      .MEM_AW  (T_MEM_AW),
      .MEM_LAT (T_MEM_LAT)
   ) dut_i (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_i_addr  (i_i_addr),
      .i_i_rd_en (i_i_rd_en),
      .o_instr   (o_instr),
      .o_i_busy  (o_i_busy),
      .i_d_addr  (i_d_addr),
      .i_d_wdata (i_d_wdata),
      .i_d_rd_en (i_d_rd_en),
      .i_d_wr_en (i_d_wr_en),
      .o_d_rdata (o_d_rdata),
      .o_d_busy  (o_d_busy)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // memory only decodes the low address bits
   function automatic word_t expected_word(input addr_t a);
      return shadow[a[T_MEM_AW-1:0]];
   endfunction

   // a returned word is final once busy is low with the enable set
   always @(negedge clk) begin
      if (i_d_rd_en && !o_d_busy) begin
         checks++;
         assert (o_d_rdata === expected_word(i_d_addr)) else begin
            $display("FAILED at %0t: data read %h gave %h, expected %h",
                     $time, i_d_addr, o_d_rdata, expected_word(i_d_addr));
            errors++;
         end
      end
      if (i_i_rd_en && !o_i_busy) begin
         checks++;
         assert (o_instr === expected_word(i_i_addr)) else begin
            $display("FAILED at %0t: fetch %h gave %h, expected %h",
                     $time, i_i_addr, o_instr, expected_word(i_i_addr));
            errors++;
         end
      end
   end

   task automatic data_write(input addr_t a, input word_t d);
      @(posedge clk);
      #2;
      i_d_addr  = a;
      i_d_wdata = d;
      i_d_wr_en = 1'b1;
      shadow[a[T_MEM_AW-1:0]] = d;
      do @(negedge clk); while (o_d_busy);   // low in the cycle after vld
      @(posedge clk);
      #2;
      i_d_wr_en = 1'b0;
   endtask

   task automatic data_read(input addr_t a, output logic saw_busy, output time t_done);
      @(posedge clk);
      #2;
      i_d_addr  = a;
      i_d_rd_en = 1'b1;
      saw_busy  = 1'b0;
      @(negedge clk);
      while (o_d_busy) begin
         saw_busy = 1'b1;
         @(negedge clk);
      end
      t_done = $time;
      @(posedge clk);
      #2;
      i_d_rd_en = 1'b0;
   endtask

   task automatic instr_fetch(input addr_t a, output time t_done);
      @(posedge clk);
      #2;
      i_i_addr  = a;
      i_i_rd_en = 1'b1;
      @(negedge clk);
      while (o_i_busy) begin
         @(negedge clk);
      end
      t_done = $time;
      @(posedge clk);
      #2;
      i_i_rd_en = 1'b0;
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("test %s: passed", name);
      end else begin
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end
   endtask

   initial begin
      int   e0;
      logic busy_seen;
      time  t_i;
      time  t_d;

      void'($urandom(32'ha3f6));
      i_arst_n  = 1'b0;
      i_i_addr  = '0;
      i_i_rd_en = 1'b0;
      i_d_addr  = '0;
      i_d_wdata = '0;
      i_d_rd_en = 1'b0;
      i_d_wr_en = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      i_arst_n = 1'b1;

      // test 1 writes distinct addresses below 0x80
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         test_addr[i] = addr_t'(i * 8 + ($urandom % 8));
         data_write(test_addr[i], word_t'($urandom));
      end
      for (int i = 0; i < 16; i++) begin
         data_read(test_addr[i], busy_seen, t_d);
      end
      report_test("write then read", e0);

      // test 2 rereads the line filled by the last read
      e0 = errors;
      data_read(test_addr[15], busy_seen, t_d);
      checks++;
      assert (!busy_seen) else begin
         $display("FAILED at %0t: o_d_busy rose on a read hit at %h", $time, test_addr[15]);
         errors++;
      end
      report_test("data hit", e0);

      // test 3
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         instr_fetch(test_addr[i], t_i);
      end
      report_test("fetch shared memory", e0);

      // test 4 alternates two addresses at index 0
      e0 = errors;
      data_write(16'h0080, word_t'($urandom));
      data_write(16'h0088, word_t'($urandom));
      for (int i = 0; i < 4; i++) begin
         data_read((i % 2 == 0) ? 16'h0080 : 16'h0088, busy_seen, t_d);
      end
      report_test("eviction", e0);

      // test 5 writes 0x88 while it is cached
      e0 = errors;
      data_write(16'h0088, word_t'($urandom));
      data_read(16'h0088, busy_seen, t_d);
      report_test("write hit", e0);

      // test 6 misses in both caches in the same cycle
      e0 = errors;
      data_write(16'h0090, word_t'($urandom));
      data_write(16'h0098, word_t'($urandom));
      fork
         instr_fetch(16'h0090, t_i);
         data_read(16'h0098, busy_seen, t_d);
      join
      checks++;
      assert (t_i < t_d) else begin
         $display("FAILED at %0t: o_i_busy fell at %0t, not before o_d_busy at %0t",
                  $time, t_i, t_d);
         errors++;
      end
      report_test("priority", e0);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WDOG_CYC) @(posedge clk);
      $display("the run timed out after %0d cycles without finishing the tests", WDOG_CYC);
      $display("Something failed");
      $finish;
   end

endmodule
